//--- channel_acq_controller.sv
// channel acquisition controller that delays, fires the channels and logs the event

module channel_acq_controller
    import trigger_pkg::*;
    import readout_pkg::*;
(
    input  logic       ttc_clk,
    input  logic       rst_n,

    // from the trigger receiver
    input  logic       trigger,     // one-cycle pulse
    input  trig_num_t  trig_num,
    input  trig_type_t trig_type,
    output logic       acq_ready,   // high only while idle

    // configuration, latched per trigger
    input  chan_mask_t chan_en,
    input  delay_t     trig_delay,

    // channel FPGAs
    input  chan_mask_t chan_dones,  // may be pulses
    output chan_mask_t chan_enable,
    output chan_mask_t chan_trig,

    // event FIFO write side
    input  logic       fifo_full,
    output logic       fifo_push,
    output acq_event_t fifo_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DELAY,
        S_WAIT_DONES,
        S_WRITE
    } state_t;

    state_t     state;
    delay_t     delay_cnt;  // cycles left before firing
    chan_mask_t mask;       // latched chan_en
    chan_mask_t dones_seen; // latched done flags
    chan_mask_t dones_now;
    trig_num_t  ev_num;
    trig_type_t ev_type;

    assign dones_now = (dones_seen | chan_dones) & mask; // disabled ones ignored
    assign acq_ready = (state == S_IDLE);
    assign fifo_push = (state == S_WRITE) && !fifo_full; // stall while full
    assign fifo_data = '{trig_num: ev_num, trig_type: ev_type};

    // ------------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            delay_cnt   <= '0;
            dones_seen  <= '0;
            chan_trig   <= '0;
            chan_enable <= '0;
        end else begin
            chan_trig <= '0; // single-cycle pulse
            case (state)
                S_IDLE: begin
                    if (trigger) begin
                        dones_seen <= '0;
                        if (trig_delay == '0) begin // zero delay fires right away
                            chan_trig   <= chan_en;
                            chan_enable <= chan_en;
                            state       <= S_WAIT_DONES;
                        end else begin
                            delay_cnt <= trig_delay;
                            state     <= S_DELAY;
                        end
                    end
                end
                S_DELAY: begin
                    if (delay_cnt == delay_t'(1)) begin
                        chan_trig   <= mask;
                        chan_enable <= mask;
                        state       <= S_WAIT_DONES;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                S_WAIT_DONES: begin
                    dones_seen <= dones_now;
                    if (dones_now == mask) begin // last enabled done in
                        chan_enable <= '0;
                        state       <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (!fifo_full) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // per-trigger payload
    always_ff @(posedge ttc_clk) begin
        if (state == S_IDLE && trigger) begin
            mask    <= chan_en;
            ev_num  <= trig_num;
            ev_type <= trig_type;
        end
    end

    // receiver must honour acq_ready
    a_trig_when_idle: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        trigger |-> state == S_IDLE);
    a_chan_trig_pulse: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (chan_trig != '0) |=> (chan_trig == '0));

endmodule

//--- readout_pkg.sv
// channel-side widths and the acquisition event record format

package readout_pkg;

    import trigger_pkg::*;

    // ------------------------------------------------------------------------
    // channel configuration
    // ------------------------------------------------------------------------

    localparam int NUM_CHAN    = 5; // channel FPGAs on the board
    localparam int DELAY_WIDTH = 8; // trigger delay in ttc_clk cycles

    typedef logic [NUM_CHAN-1:0]    chan_mask_t; // one bit per channel
    typedef logic [DELAY_WIDTH-1:0] delay_t;

    // one entry of the acquisition event FIFO, 29 bits
    typedef struct packed {
        trig_num_t  trig_num;  // number the channels were fired for
        trig_type_t trig_type;
    } acq_event_t;

endpackage

//--- record_fifo.sv
// single-clock first-word fall-through FIFO holding one record type

module record_fifo #(
    parameter int  FIFO_DEPTH = 16,          // power of two
    parameter type record_t   = logic [31:0] // record carried per entry
) (
    input  logic    ttc_clk,
    input  logic    rst_n,
    input  logic    push,
    input  record_t push_data,
    input  logic    pop,
    output record_t pop_data,
    output logic    empty,
    output logic    full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    record_t          mem [FIFO_DEPTH]; // circular buffer
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;            // occupancy, 0..FIFO_DEPTH
    logic             wr_en;
    logic             rd_en;

    assign wr_en    = push & ~full;  // overflow never corrupts the buffer
    assign rd_en    = pop & ~empty;
    assign empty    = (count == '0);
    assign full     = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign pop_data = mem[rd_ptr];   // head is always visible

    // pointers wrap by themselves since depth is a power of two
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (wr_en) mem[wr_ptr] <= push_data;
    end

    // writers and readers are expected to watch the flags themselves
    a_no_push_full: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        push |-> !full);
    a_no_pop_empty: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the trigger path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_trigger_top -f sources.f
out=$(./obj_dir/Vtb_trigger_top)
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+.
trigger_pkg.sv
readout_pkg.sv
record_fifo.sv
ttc_trigger_receiver.sv
channel_acq_controller.sv
trigger_processor.sv
trigger_top.sv
tb_trigger_top.sv

//--- tb_trigger_cases.svh
// trigger case table and expected-value rules for the trigger path testbench
`ifndef TB_TRIGGER_CASES_SVH
`define TB_TRIGGER_CASES_SVH

// one row per trigger
typedef struct packed {
    trig_type_t ttype;
    chan_mask_t mask;      // never zero, chan_trig must be visible
    delay_t     delay;
    logic [7:0] done_lat;  // chan_trig to done, before jitter, at least 1
    logic [7:0] ack_lat;   // readout_req to readout_ack
    logic       busy_trig; // second trigger while channels are busy
} trig_case_t;

localparam int NUM_CASES = 9;

// last four rows: slow command manager, triggers pile up in both FIFOs
localparam trig_case_t CASES [NUM_CASES] = '{
    '{TRIG_TYPE_MUON,     5'b11111, 8'd3,  8'd4, 8'd2,  1'b0},
    '{TRIG_TYPE_LASER,    5'b00101, 8'd0,  8'd1, 8'd5,  1'b0},
    '{TRIG_TYPE_PEDESTAL, 5'b10010, 8'd7,  8'd3, 8'd1,  1'b1},
    '{TRIG_TYPE_MUON,     5'b01000, 8'd1,  8'd2, 8'd0,  1'b0},
    '{TRIG_TYPE_LASER,    5'b11111, 8'd12, 8'd6, 8'd3,  1'b1},
    '{TRIG_TYPE_MUON,     5'b00011, 8'd2,  8'd1, 8'd60, 1'b0},
    '{TRIG_TYPE_PEDESTAL, 5'b11100, 8'd0,  8'd1, 8'd60, 1'b0},
    '{TRIG_TYPE_MUON,     5'b10101, 8'd1,  8'd2, 8'd60, 1'b0},
    '{TRIG_TYPE_LASER,    5'b01111, 8'd2,  8'd1, 8'd60, 1'b0}
};

// edges from the raising edge to the one that carries chan_trig
function automatic int chan_trig_edges(input delay_t delay);
    return int'(delay) + 2; // accept edge, acq_trigger, then the delay
endfunction

`endif

//--- tb_trigger_top.sv
// testbench for the TTC trigger path with channel and command manager models

module tb_trigger_top
    import trigger_pkg::*;
    import readout_pkg::*;
();

    localparam int REQ_TIMEOUT = 2000; // cycles allowed per readout_req wait

    logic       ttc_clk;
    logic       rst_n;
    logic       ttc_trigger;
    trig_type_t trig_type;
    chan_mask_t chan_en;
    delay_t     trig_delay;
    chan_mask_t chan_dones;
    logic       readout_ack;
    chan_mask_t chan_enable;
    chan_mask_t chan_trig;
    logic       readout_req;
    trig_num_t  ttc_trig_num;
    trig_type_t ttc_trig_type;
    timestamp_t ttc_trig_timestamp;
    logic       error_trig_rate;
    logic       error_trig_num;
    logic       error_trig_type;

    // expected readout, queued when the trigger goes up
    typedef struct {
        trig_num_t  num;
        trig_type_t ttype;
        int         cycle;   // cycle_cnt at the raise
        int         ack_lat;
    } exp_t;

    exp_t        exp_q [$];
    int          cycle_cnt;
    int          accepted;       // triggers that should have been taken
    logic        rate_expected;  // model of the sticky rate error
    int unsigned lcg_state;
    int          mismatch_count;
    int          timeout_count;

    `include "tb_trigger_cases.svh"

    trigger_top #(.FIFO_DEPTH(16)) dut_i (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .ttc_trigger(ttc_trigger), .trig_type(trig_type),
        .chan_en(chan_en), .trig_delay(trig_delay),
        .chan_dones(chan_dones), .chan_enable(chan_enable), .chan_trig(chan_trig),
        .readout_ack(readout_ack), .readout_req(readout_req),
        .ttc_trig_num(ttc_trig_num), .ttc_trig_type(ttc_trig_type),
        .ttc_trig_timestamp(ttc_trig_timestamp),
        .error_trig_rate(error_trig_rate), .error_trig_num(error_trig_num),
        .error_trig_type(error_trig_type)
    );

    initial begin
        ttc_clk = 1'b0;
        forever #20 ttc_clk = ~ttc_clk; // 40 per cycle
    end

    always @(posedge ttc_clk) begin
        if (!rst_n) cycle_cnt <= 0;
        else        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16; // low bits of an LCG are poor
    endfunction

    // outputs settled, inputs may change
    task automatic next_cycle();
        @(posedge ttc_clk);
        #2;
    endtask

    task automatic mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        mismatch_count = mismatch_count + 1;
    endtask

    task automatic timeout_error(input string what);
        $display("Error at time %0t: timed out waiting for %s", $time, what);
        timeout_count = timeout_count + 1;
    endtask

    task automatic check_quiet(input string when);
        assert (chan_trig == '0 && chan_enable == '0 && !readout_req &&
                !error_trig_rate && !error_trig_num && !error_trig_type)
        else mismatch({"outputs not idle ", when});
    endtask

    task automatic wait_req(input logic level, output bit ok);
        ok = (readout_req == level);
        for (int n = 0; n < REQ_TIMEOUT && !ok; n++) begin
            next_cycle();
            ok = (readout_req == level);
        end
    endtask

    // ------------------------------------------------------------------------
    // trigger source and channel model
    // ------------------------------------------------------------------------

    task automatic run_case(input int idx);
        trig_case_t tc;
        int         lat [NUM_CHAN]; // done latency per channel
        int         max_lat;
        int         edges;
        chan_mask_t dones;
        exp_t       e;
        tc      = CASES[idx];
        max_lat = 0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            lat[c] = int'(tc.done_lat) + int'(lcg_next() % 4); // jitter 0..3
            if (tc.mask[c] && lat[c] > max_lat) max_lat = lat[c];
        end
        trig_type   = tc.ttype;
        chan_en     = tc.mask;
        trig_delay  = tc.delay;
        ttc_trigger = 1'b1;
        accepted    = accepted + 1; // number of this trigger
        e.num       = trig_num_t'(accepted);
        e.ttype     = tc.ttype;
        e.cycle     = cycle_cnt;
        e.ack_lat   = int'(tc.ack_lat);
        exp_q.push_back(e);
        edges = chan_trig_edges(tc.delay);
        for (int k = 1; k <= edges; k++) begin
            next_cycle();
            ttc_trigger = 1'b0;
            if (k < edges) begin
                assert (chan_trig == '0)
                else mismatch($sformatf("chan_trig early, row %0d edge %0d", idx, k));
            end else begin
                assert (chan_trig == tc.mask && chan_enable == tc.mask)
                else mismatch($sformatf("chan_trig %b enable %b, row %0d expects %b",
                    chan_trig, chan_enable, idx, tc.mask));
            end
        end
        assert (error_trig_rate == rate_expected)
        else mismatch($sformatf("error_trig_rate %b before row %0d", error_trig_rate, idx));
        // dones come back as one-cycle pulses
        for (int k = 0; k <= max_lat; k++) begin
            if (k > 0) begin
                next_cycle();
                assert (chan_trig == '0)
                else mismatch($sformatf("extra chan_trig pulse in row %0d", idx));
            end
            assert (chan_enable == tc.mask)
            else mismatch($sformatf("chan_enable %b dropped early, row %0d", chan_enable, idx));
            if (tc.busy_trig) ttc_trigger = (k == 0); // lands in wait-dones
            dones = '0;
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (tc.mask[c] && lat[c] == k) dones[c] = 1'b1;
            end
            chan_dones = dones;
        end
        if (tc.busy_trig) rate_expected = 1'b1;
        next_cycle();
        chan_dones = '0;
        assert (chan_enable == '0)
        else mismatch($sformatf("chan_enable still %b after last done, row %0d",
            chan_enable, idx));
        assert (error_trig_rate == rate_expected)
        else mismatch($sformatf("error_trig_rate %b after row %0d", error_trig_rate, idx));
        repeat (2) next_cycle(); // event write, back to idle
    endtask

    // ------------------------------------------------------------------------
    // command manager model
    // ------------------------------------------------------------------------

    task automatic serve_readouts();
        exp_t       e;
        bit         ok;
        bit         have_prev;
        timestamp_t prev_ts;
        int         prev_cycle;
        have_prev  = 1'b0;
        prev_ts    = '0;
        prev_cycle = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            wait_req(1'b1, ok);
            if (!ok) begin
                timeout_error($sformatf("readout_req of readout %0d", i));
                return;
            end
            if (exp_q.size() == 0) begin
                mismatch("readout_req with no accepted trigger");
                return;
            end
            e = exp_q.pop_front();
            assert (ttc_trig_num == e.num && ttc_trig_type == e.ttype)
            else mismatch($sformatf("readout num %0d type %0d, expected num %0d type %0d",
                ttc_trig_num, ttc_trig_type, e.num, e.ttype));
            if (have_prev) begin
                assert (ttc_trig_timestamp - prev_ts == timestamp_t'(e.cycle - prev_cycle))
                else mismatch($sformatf("timestamp step %0d, expected %0d",
                    ttc_trig_timestamp - prev_ts, e.cycle - prev_cycle));
            end
            assert (!error_trig_num && !error_trig_type)
            else mismatch("trigger number or type cross-check flag set");
            prev_ts    = ttc_trig_timestamp;
            prev_cycle = e.cycle;
            have_prev  = 1'b1;
            for (int j = 0; j < e.ack_lat; j++) begin
                next_cycle();
                assert (readout_req)
                else mismatch("readout_req fell before readout_ack");
            end
            readout_ack = 1'b1;
            wait_req(1'b0, ok);
            if (!ok) begin
                timeout_error("readout_req to fall after readout_ack");
                return;
            end
            assert (ttc_trig_num == e.num)
            else mismatch("ttc_trig_num changed during the handshake");
            // ack held a few cycles, queued records wait for it to drop
            repeat (3) begin
                next_cycle();
                assert (!readout_req)
                else mismatch("new readout_req before readout_ack dropped");
            end
            readout_ack = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        rst_n          = 1'b0;
        ttc_trigger    = 1'b0;
        trig_type      = '0;
        chan_en        = '0;
        trig_delay     = '0;
        chan_dones     = '0;
        readout_ack    = 1'b0;
        lcg_state      = 74;
        accepted       = 0;
        rate_expected  = 1'b0;
        mismatch_count = 0;
        timeout_count  = 0;
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            check_quiet("during reset");
        end
        rst_n = 1'b1;
        repeat (3) begin
            next_cycle();
            check_quiet("after reset");
        end
        fork
            begin
                for (int i = 0; i < NUM_CASES; i++) run_case(i);
            end
            serve_readouts();
        join
        repeat (5) next_cycle();
        assert (!readout_req && exp_q.size() == 0)
        else mismatch("readout left over after the last trigger");
        assert (error_trig_rate == rate_expected)
        else mismatch("error_trig_rate wrong at the end");
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- trigger_pkg.sv
// trigger-side widths, trigger type codes and the trigger record format

package trigger_pkg;

    // ------------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------------

    localparam int TRIG_NUM_WIDTH  = 24; // global trigger number
    localparam int TRIG_TYPE_WIDTH = 5;  // trigger type code
    localparam int TIMESTAMP_WIDTH = 44; // free-running ttc_clk count

    typedef logic [TRIG_NUM_WIDTH-1:0]  trig_num_t;
    typedef logic [TRIG_TYPE_WIDTH-1:0] trig_type_t;
    typedef logic [TIMESTAMP_WIDTH-1:0] timestamp_t;

    // ------------------------------------------------------------------------
    // trigger type codes
    // ------------------------------------------------------------------------

    localparam trig_type_t TRIG_TYPE_MUON     = 5'd1; // muon fill
    localparam trig_type_t TRIG_TYPE_LASER    = 5'd2; // laser calibration
    localparam trig_type_t TRIG_TYPE_PEDESTAL = 5'd3; // pedestal run

    // one entry of the trigger FIFO, 73 bits
    // timestamp on top so the number/type low bits line up with the event record
    typedef struct packed {
        timestamp_t timestamp; // stamp taken at the accepting edge
        trig_num_t  trig_num;  // starts at 1 after reset
        trig_type_t trig_type;
    } trig_info_t;

endpackage

//--- trigger_processor.sv
// trigger processor that pairs both FIFO records and requests a readout

module trigger_processor
    import trigger_pkg::*;
    import readout_pkg::*;
(
    input  logic       ttc_clk,
    input  logic       rst_n,

    // trigger FIFO read side
    input  logic       trig_empty,
    input  trig_info_t trig_data,  // head record, fall-through
    output logic       trig_pop,

    // event FIFO read side
    input  logic       acq_empty,
    input  acq_event_t acq_data,
    output logic       acq_pop,

    // command manager, four-phase handshake
    input  logic       readout_ack,
    output logic       readout_req,
    output trig_num_t  ttc_trig_num,
    output trig_type_t ttc_trig_type,
    output timestamp_t ttc_trig_timestamp,

    output logic       error_trig_num,  // sticky number mismatch
    output logic       error_trig_type  // sticky type mismatch
);

    typedef enum logic [1:0] {
        S_IDLE,    // waiting for a record in each FIFO
        S_REQUEST, // req high, waiting for ack
        S_RELEASE  // req low, waiting for ack to drop
    } state_t;

    state_t state;
    logic   pop_both;

    // both records leave together
    assign pop_both = (state == S_IDLE) && !trig_empty && !acq_empty;
    assign trig_pop = pop_both;
    assign acq_pop  = pop_both;

    // ------------------------------------------------------------------------
    // handshake FSM and cross-check
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            readout_req     <= 1'b0;
            error_trig_num  <= 1'b0;
            error_trig_type <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pop_both) begin
                        readout_req <= 1'b1;
                        state       <= S_REQUEST;
                        if (trig_data.trig_num != acq_data.trig_num) error_trig_num <= 1'b1;
                        if (trig_data.trig_type != acq_data.trig_type) error_trig_type <= 1'b1;
                    end
                end
                S_REQUEST: begin
                    if (readout_ack) begin
                        readout_req <= 1'b0;
                        state       <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!readout_ack) state <= S_IDLE; // ready for the next pair
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // readout info, held until the next pop
    always_ff @(posedge ttc_clk) begin
        if (pop_both) begin
            ttc_trig_num       <= trig_data.trig_num;
            ttc_trig_type      <= trig_data.trig_type;
            ttc_trig_timestamp <= trig_data.timestamp;
        end
    end

    // command manager sees req until it has answered
    a_req_held: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        $fell(readout_req) |-> $past(readout_ack));

endmodule

//--- trigger_top.sv
// top level of the synchronous TTC trigger path from receiver to readout request

module trigger_top
    import trigger_pkg::*;
    import readout_pkg::*;
#(
    parameter int FIFO_DEPTH = 16 // depth of both record FIFOs
) (
    input  logic       ttc_clk,  // 40 MHz TTC clock
    input  logic       rst_n,

    // trigger and configuration
    input  logic       ttc_trigger,
    input  trig_type_t trig_type,
    input  chan_mask_t chan_en,
    input  delay_t     trig_delay,

    // channel FPGAs
    input  chan_mask_t chan_dones,
    output chan_mask_t chan_enable,
    output chan_mask_t chan_trig,

    // command manager
    input  logic       readout_ack,
    output logic       readout_req,
    output trig_num_t  ttc_trig_num,
    output trig_type_t ttc_trig_type,
    output timestamp_t ttc_trig_timestamp,

    // errors
    output logic       error_trig_rate,
    output logic       error_trig_num,
    output logic       error_trig_type
);

    // ------------------------------------------------------------------------
    // interconnect
    // ------------------------------------------------------------------------

    logic       acq_ready;
    logic       acq_trigger;
    trig_num_t  acq_trig_num;
    trig_type_t acq_trig_type;

    logic       trig_push;     // receiver -> trigger FIFO
    trig_info_t trig_push_data;
    logic       trig_full;
    logic       trig_pop;      // trigger FIFO -> processor
    trig_info_t trig_pop_data;
    logic       trig_empty;

    logic       acq_push;      // controller -> event FIFO
    acq_event_t acq_push_data;
    logic       acq_full;
    logic       acq_pop;       // event FIFO -> processor
    acq_event_t acq_pop_data;
    logic       acq_empty;

    // ------------------------------------------------------------------------
    // instances
    // ------------------------------------------------------------------------

    ttc_trigger_receiver ttc_trigger_receiver (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .trigger(ttc_trigger), .trig_type(trig_type),
        .acq_ready(acq_ready), .acq_trigger(acq_trigger),
        .acq_trig_num(acq_trig_num), .acq_trig_type(acq_trig_type),
        .fifo_full(trig_full), .fifo_push(trig_push), .fifo_data(trig_push_data),
        .error_trig_rate(error_trig_rate)
    );

    channel_acq_controller channel_acq_controller (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .trigger(acq_trigger), .trig_num(acq_trig_num), .trig_type(acq_trig_type),
        .acq_ready(acq_ready), .chan_en(chan_en), .trig_delay(trig_delay),
        .chan_dones(chan_dones), .chan_enable(chan_enable), .chan_trig(chan_trig),
        .fifo_full(acq_full), .fifo_push(acq_push), .fifo_data(acq_push_data)
    );

    // trigger FIFO: timestamp, number, type
    record_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .record_t(trig_info_t)) trig_info_fifo (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .push(trig_push), .push_data(trig_push_data), .pop(trig_pop),
        .pop_data(trig_pop_data), .empty(trig_empty), .full(trig_full)
    );

    // event FIFO: number and type of each completed acquisition
    record_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .record_t(acq_event_t)) acq_event_fifo (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .push(acq_push), .push_data(acq_push_data), .pop(acq_pop),
        .pop_data(acq_pop_data), .empty(acq_empty), .full(acq_full)
    );

    trigger_processor trigger_processor (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .trig_empty(trig_empty), .trig_data(trig_pop_data), .trig_pop(trig_pop),
        .acq_empty(acq_empty), .acq_data(acq_pop_data), .acq_pop(acq_pop),
        .readout_ack(readout_ack), .readout_req(readout_req),
        .ttc_trig_num(ttc_trig_num), .ttc_trig_type(ttc_trig_type),
        .ttc_trig_timestamp(ttc_trig_timestamp),
        .error_trig_num(error_trig_num), .error_trig_type(error_trig_type)
    );

endmodule

//--- ttc_trigger_receiver.sv
// TTC trigger receiver that accepts, numbers and timestamps backplane triggers

module ttc_trigger_receiver
    import trigger_pkg::*;
(
    input  logic       ttc_clk,
    input  logic       rst_n,

    // backplane trigger
    input  logic       trigger,
    input  trig_type_t trig_type,

    // channel acquisition controller side
    input  logic       acq_ready,     // controller is idle
    output logic       acq_trigger,   // one-cycle pulse per accepted trigger
    output trig_num_t  acq_trig_num,
    output trig_type_t acq_trig_type,

    // trigger FIFO write side
    input  logic       fifo_full,
    output logic       fifo_push,
    output trig_info_t fifo_data,

    output logic       error_trig_rate // sticky, trigger arrived while busy
);

    logic       trigger_d; // last sample of trigger
    logic       trig_edge;
    logic       accept;
    trig_num_t  trig_cnt;  // triggers accepted so far
    trig_num_t  next_num;
    timestamp_t timestamp; // free-running cycle count

    assign trig_edge = trigger & ~trigger_d;             // low then high
    assign accept    = trig_edge & acq_ready & ~fifo_full;
    assign next_num  = trig_cnt + 1'b1;                  // first one is 1

    // ------------------------------------------------------------------------
    // counters and flags
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            trigger_d       <= 1'b1; // a level held through reset is no edge
            trig_cnt        <= '0;
            timestamp       <= '0;
            acq_trigger     <= 1'b0;
            fifo_push       <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            trigger_d   <= trigger;
            timestamp   <= timestamp + 1'b1;
            acq_trigger <= accept; // controller and FIFO see it together
            fifo_push   <= accept;
            if (accept) trig_cnt <= next_num;
            // dropped triggers leave the number alone
            if (trig_edge && !accept) error_trig_rate <= 1'b1;
        end
    end

    // record of the accepted trigger, stamped at the accepting edge
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            acq_trig_num        <= next_num;
            acq_trig_type       <= trig_type;
            fifo_data.timestamp <= timestamp;
            fifo_data.trig_num  <= next_num;
            fifo_data.trig_type <= trig_type;
        end
    end

    // full is sampled one cycle before the write lands in the FIFO
    a_push_not_full: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        fifo_push |-> !fifo_full);

endmodule
